// File: csr_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared CSR definitions: word and index types, machine CSR index
// map, read select enumeration, field bit positions and the
// identification constants
//////////////////////////////////////////////////////////////////////
`default_nettype none

package csr_pkg;

  localparam int XLEN = 32;                     // CSR word width

  typedef logic [XLEN-1:0] csr_word_t;
  typedef logic [11:0]     csr_idx_t;

  // Machine CSR index map
  localparam csr_idx_t CSR_MSTATUS     = 12'h300;
  localparam csr_idx_t CSR_MISA        = 12'h301;
  localparam csr_idx_t CSR_MIE         = 12'h304;
  localparam csr_idx_t CSR_MTVEC       = 12'h305;
  localparam csr_idx_t CSR_MSCRATCH    = 12'h340;
  localparam csr_idx_t CSR_MEPC        = 12'h341;
  localparam csr_idx_t CSR_MCAUSE      = 12'h342;
  localparam csr_idx_t CSR_MIP         = 12'h344;
  localparam csr_idx_t CSR_MCYCLE      = 12'hB00;
  localparam csr_idx_t CSR_MINSTRET    = 12'hB02;
  localparam csr_idx_t CSR_MCYCLEH     = 12'hB80;
  localparam csr_idx_t CSR_MINSTRETH   = 12'hB82;
  localparam csr_idx_t CSR_COUNTERSTOP = 12'hBFF;   // Custom, free index
  localparam csr_idx_t CSR_MVENDORID   = 12'hF11;
  localparam csr_idx_t CSR_MARCHID     = 12'hF12;
  localparam csr_idx_t CSR_MIMPID      = 12'hF13;
  localparam csr_idx_t CSR_MHARTID     = 12'hF14;

  // One-of-N read select, SEL_NONE reads zero
  typedef enum logic [4:0] {
    SEL_NONE, SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC,
    SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MIP,
    SEL_MCYCLE, SEL_MINSTRET, SEL_MCYCLEH, SEL_MINSTRETH,
    SEL_COUNTERSTOP, SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID
  } csr_sel_e;

  // Field positions
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int IRQ_SOFT     = 3;              // Shared by mie and mip
  localparam int IRQ_TIMER    = 7;
  localparam int IRQ_EXT      = 11;
  localparam int CAUSE_INT    = 31;             // Interrupt flag of mcause

  localparam int MCAUSE_CODE_W = 4;

  // RV32 with I, M and C
  localparam csr_word_t MISA_VALUE      = 32'h4000_1104;
  localparam csr_word_t MVENDORID_VALUE = 32'h0000_0000;  // Non-commercial
  localparam csr_word_t MARCHID_VALUE   = 32'h0000_0001;
  localparam csr_word_t MIMPID_VALUE    = 32'h0000_0001;

  localparam int HART_ID_W = 1;

endpackage

`default_nettype wire

// File: csr_decode.sv
//////////////////////////////////////////////////////////////////////
// CSR index decoder: read select, per-register write strobes
// and the illegal access flag
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module csr_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              csr_ena,
  input  logic              csr_rd_en,
  input  logic              csr_wr_en,
  input  csr_pkg::csr_idx_t csr_idx,
  output csr_pkg::csr_sel_e rd_sel,
  output logic              csr_access_ilgl,
  output logic              wr_mstatus,
  output logic              wr_mie,
  output logic              wr_mtvec,
  output logic              wr_mscratch,
  output logic              wr_mepc,
  output logic              wr_mcause,
  output logic              wr_counterstop,
  output logic              wr_mcycle,
  output logic              wr_mcycleh,
  output logic              wr_minstret,
  output logic              wr_minstreth
);
  import csr_pkg::*;

  csr_sel_e idx_sel;                            // Register matched by index
  logic     wr_ok;

  always_comb begin
    case (csr_idx)
      CSR_MSTATUS:     idx_sel = SEL_MSTATUS;
      CSR_MISA:        idx_sel = SEL_MISA;
      CSR_MIE:         idx_sel = SEL_MIE;
      CSR_MTVEC:       idx_sel = SEL_MTVEC;
      CSR_MSCRATCH:    idx_sel = SEL_MSCRATCH;
      CSR_MEPC:        idx_sel = SEL_MEPC;
      CSR_MCAUSE:      idx_sel = SEL_MCAUSE;
      CSR_MIP:         idx_sel = SEL_MIP;
      CSR_MCYCLE:      idx_sel = SEL_MCYCLE;
      CSR_MINSTRET:    idx_sel = SEL_MINSTRET;
      CSR_MCYCLEH:     idx_sel = SEL_MCYCLEH;
      CSR_MINSTRETH:   idx_sel = SEL_MINSTRETH;
      CSR_COUNTERSTOP: idx_sel = SEL_COUNTERSTOP;
      CSR_MVENDORID:   idx_sel = SEL_MVENDORID;
      CSR_MARCHID:     idx_sel = SEL_MARCHID;
      CSR_MIMPID:      idx_sel = SEL_MIMPID;
      CSR_MHARTID:     idx_sel = SEL_MHARTID;
      default:         idx_sel = SEL_NONE;      // Not implemented
    endcase
  end

  // Unknown index, or write into the read-only range 0xC00-0xFFF
  assign csr_access_ilgl = csr_ena &
                           ((idx_sel == SEL_NONE) | (csr_wr_en & (&csr_idx[11:10])));

  assign rd_sel = (csr_ena & csr_rd_en & ~csr_access_ilgl) ? idx_sel : SEL_NONE;
  assign wr_ok  = csr_ena & csr_wr_en & ~csr_access_ilgl;

  assign wr_mstatus     = wr_ok & (idx_sel == SEL_MSTATUS);
  assign wr_mie         = wr_ok & (idx_sel == SEL_MIE);
  assign wr_mtvec       = wr_ok & (idx_sel == SEL_MTVEC);
  assign wr_mscratch    = wr_ok & (idx_sel == SEL_MSCRATCH);
  assign wr_mepc        = wr_ok & (idx_sel == SEL_MEPC);
  assign wr_mcause      = wr_ok & (idx_sel == SEL_MCAUSE);
  assign wr_counterstop = wr_ok & (idx_sel == SEL_COUNTERSTOP);
  assign wr_mcycle      = wr_ok & (idx_sel == SEL_MCYCLE);
  assign wr_mcycleh     = wr_ok & (idx_sel == SEL_MCYCLEH);
  assign wr_minstret    = wr_ok & (idx_sel == SEL_MINSTRET);
  assign wr_minstreth   = wr_ok & (idx_sel == SEL_MINSTRETH);

  // Register and counter blocks each see at most one write per cycle
  a_one_write: assert property (@(posedge clk) disable iff (rst)
    $onehot0({wr_mstatus, wr_mie, wr_mtvec, wr_mscratch, wr_mepc, wr_mcause,
              wr_counterstop, wr_mcycle, wr_mcycleh, wr_minstret, wr_minstreth}))
    else $error("more than one CSR write strobe");

endmodule

`default_nettype wire

// File: csr_machine_regs.sv
//////////////////////////////////////////////////////////////////////
// Machine trap state: mstatus MIE/MPIE, mie, mip, mtvec, mscratch,
// mepc, mcause and counterstop, with trap entry and mret updates
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module csr_machine_regs #(
  parameter csr_pkg::csr_word_t MTVEC_RESET = 32'h0000_0100
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               wr_mstatus,
  input  logic               wr_mie,
  input  logic               wr_mtvec,
  input  logic               wr_mscratch,
  input  logic               wr_mepc,
  input  logic               wr_mcause,
  input  logic               wr_counterstop,
  input  csr_pkg::csr_word_t wbck_csr_dat,
  input  logic               cmt_status_ena,  // Trap taken
  input  logic               cmt_mret_ena,
  input  logic               cmt_epc_ena,
  input  csr_pkg::csr_word_t cmt_epc,
  input  logic               cmt_cause_ena,
  input  csr_pkg::csr_word_t cmt_cause,
  input  logic               ext_irq,
  input  logic               sft_irq,
  input  logic               tmr_irq,
  output logic               status_mie,
  output logic               status_mpie,
  output logic [2:0]         mie_bits,        // {meie, mtie, msie}
  output logic [2:0]         mip_bits,        // {meip, mtip, msip}
  output csr_pkg::csr_word_t mtvec_r,
  output csr_pkg::csr_word_t mscratch_r,
  output csr_pkg::csr_word_t mepc_r,
  output csr_pkg::csr_word_t mcause_r,
  output logic [2:0]         counterstop_r
);
  import csr_pkg::*;

  logic [XLEN-1:1]          epc_q;              // Bit 0 is always zero
  logic                     cause_int_q;
  logic [MCAUSE_CODE_W-1:0] cause_code_q;

  //////////////////////////////////////////////////////////////////////
  // mstatus, trap beats mret beats a CSR write
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      status_mie  <= 1'b0;
      status_mpie <= 1'b0;
    end else if (cmt_status_ena) begin
      status_mpie <= status_mie;                // Save MIE, then mask
      status_mie  <= 1'b0;
    end else if (cmt_mret_ena) begin
      status_mie  <= status_mpie;
      status_mpie <= 1'b1;
    end else if (wr_mstatus) begin
      status_mie  <= wbck_csr_dat[MSTATUS_MIE];
      status_mpie <= wbck_csr_dat[MSTATUS_MPIE];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Interrupt enable and pending
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mie_bits <= 3'b000;
      mip_bits <= 3'b000;
    end else begin
      if (wr_mie)
        mie_bits <= {wbck_csr_dat[IRQ_EXT], wbck_csr_dat[IRQ_TIMER], wbck_csr_dat[IRQ_SOFT]};
      mip_bits <= {ext_irq, tmr_irq, sft_irq};  // Sampled lines, read only
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Trap vector, scratch, epc, cause and counter stop
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec_r       <= MTVEC_RESET;
      mscratch_r    <= '0;
      epc_q         <= '0;
      cause_int_q   <= 1'b0;
      cause_code_q  <= '0;
      counterstop_r <= 3'b000;
    end else begin
      if (wr_mtvec)
        mtvec_r <= wbck_csr_dat;
      if (wr_mscratch)
        mscratch_r <= wbck_csr_dat;
      if (cmt_epc_ena)                          // Commit wins over write
        epc_q <= cmt_epc[XLEN-1:1];
      else if (wr_mepc)
        epc_q <= wbck_csr_dat[XLEN-1:1];
      if (cmt_cause_ena) begin
        cause_int_q  <= cmt_cause[CAUSE_INT];
        cause_code_q <= cmt_cause[MCAUSE_CODE_W-1:0];
      end else if (wr_mcause) begin
        cause_int_q  <= wbck_csr_dat[CAUSE_INT];
        cause_code_q <= wbck_csr_dat[MCAUSE_CODE_W-1:0];
      end
      if (wr_counterstop)
        counterstop_r <= wbck_csr_dat[2:0];     // cy, tm, ir stop
    end
  end

  assign mepc_r   = {epc_q, 1'b0};
  assign mcause_r = {cause_int_q, {(XLEN-1-MCAUSE_CODE_W){1'b0}}, cause_code_q};

  // Commit stage never takes a trap and retires an mret together
  a_trap_mret: assert property (@(posedge clk) disable iff (rst)
    !(cmt_status_ena && cmt_mret_ena))
    else $error("trap and mret committed in the same cycle");

endmodule

`default_nettype wire

// File: csr_counter.sv
//////////////////////////////////////////////////////////////////////
// 64-bit event counter as a writable low/high word pair,
// used for mcycle and minstret
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module csr_counter (
  input  logic               clk,
  input  logic               rst,
  input  logic               inc,           // Count enable, stop already applied
  input  logic               wr_lo,
  input  logic               wr_hi,
  input  csr_pkg::csr_word_t wbck_csr_dat,
  output csr_pkg::csr_word_t cnt_lo,
  output csr_pkg::csr_word_t cnt_hi
);
  import csr_pkg::*;

  logic      carry;                          // Low word wraps this edge
  csr_word_t lo_nxt;
  csr_word_t hi_nxt;

  assign carry = inc & (cnt_lo == '1);

  // A word write replaces that word's increment
  assign lo_nxt = wr_lo ? wbck_csr_dat : cnt_lo + XLEN'(inc);
  assign hi_nxt = wr_hi ? wbck_csr_dat : cnt_hi + XLEN'(carry);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_lo <= '0;
      cnt_hi <= '0;
    end else begin
      cnt_lo <= lo_nxt;
      cnt_hi <= hi_nxt;
    end
  end

endmodule

`default_nettype wire

// File: csr_read_mux.sv
//////////////////////////////////////////////////////////////////////
// CSR read path: builds each register image and returns the one
// picked by the decoder, zero when nothing is selected
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module csr_read_mux (
  input  csr_pkg::csr_sel_e               rd_sel,
  input  logic                            status_mie,
  input  logic                            status_mpie,
  input  logic [2:0]                      mie_bits,
  input  logic [2:0]                      mip_bits,
  input  csr_pkg::csr_word_t              mtvec_r,
  input  csr_pkg::csr_word_t              mscratch_r,
  input  csr_pkg::csr_word_t              mepc_r,
  input  csr_pkg::csr_word_t              mcause_r,
  input  logic [2:0]                      counterstop_r,
  input  csr_pkg::csr_word_t              mcycle_lo,
  input  csr_pkg::csr_word_t              mcycle_hi,
  input  csr_pkg::csr_word_t              minstret_lo,
  input  csr_pkg::csr_word_t              minstret_hi,
  input  logic [csr_pkg::HART_ID_W-1:0]   core_mhartid,
  output csr_pkg::csr_word_t              read_csr_dat
);
  import csr_pkg::*;

  csr_word_t mstatus_img;
  csr_word_t mie_img;
  csr_word_t mip_img;

  // Place {ext, timer, soft} at their architectural bits
  function automatic csr_word_t irq_image(input logic [2:0] bits);
    csr_word_t img;
    img            = '0;
    img[IRQ_EXT]   = bits[2];
    img[IRQ_TIMER] = bits[1];
    img[IRQ_SOFT]  = bits[0];
    return img;
  endfunction

  always_comb begin
    mstatus_img               = '0;         // SD, XS, FS read zero
    mstatus_img[12:11]        = 2'b11;      // MPP, machine only
    mstatus_img[MSTATUS_MPIE] = status_mpie;
    mstatus_img[MSTATUS_MIE]  = status_mie;
  end

  assign mie_img = irq_image(mie_bits);
  assign mip_img = irq_image(mip_bits);

  //////////////////////////////////////////////////////////////////////
  // Select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (rd_sel)
      SEL_MSTATUS:     read_csr_dat = mstatus_img;
      SEL_MISA:        read_csr_dat = MISA_VALUE;
      SEL_MIE:         read_csr_dat = mie_img;
      SEL_MTVEC:       read_csr_dat = mtvec_r;
      SEL_MSCRATCH:    read_csr_dat = mscratch_r;
      SEL_MEPC:        read_csr_dat = mepc_r;
      SEL_MCAUSE:      read_csr_dat = mcause_r;
      SEL_MIP:         read_csr_dat = mip_img;
      SEL_MCYCLE:      read_csr_dat = mcycle_lo;
      SEL_MINSTRET:    read_csr_dat = minstret_lo;
      SEL_MCYCLEH:     read_csr_dat = mcycle_hi;
      SEL_MINSTRETH:   read_csr_dat = minstret_hi;
      SEL_COUNTERSTOP: read_csr_dat = {{(XLEN-3){1'b0}}, counterstop_r};
      SEL_MVENDORID:   read_csr_dat = MVENDORID_VALUE;
      SEL_MARCHID:     read_csr_dat = MARCHID_VALUE;
      SEL_MIMPID:      read_csr_dat = MIMPID_VALUE;
      SEL_MHARTID:     read_csr_dat = {{(XLEN-HART_ID_W){1'b0}}, core_mhartid};
      default:         read_csr_dat = '0;   // SEL_NONE or illegal
    endcase
  end

endmodule

`default_nettype wire

// File: csr_file.sv
//////////////////////////////////////////////////////////////////////
// Machine-mode CSR file top: decoder, trap registers, cycle and
// instret counters and the read multiplexer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module csr_file #(
  parameter csr_pkg::csr_word_t MTVEC_RESET = 32'h0000_0100
) (
  input  logic                          clk,
  input  logic                          rst,
  // Execute stage access
  input  logic                          csr_ena,
  input  logic                          csr_rd_en,
  input  logic                          csr_wr_en,
  input  csr_pkg::csr_idx_t             csr_idx,
  input  csr_pkg::csr_word_t            wbck_csr_dat,
  output csr_pkg::csr_word_t            read_csr_dat,
  output logic                          csr_access_ilgl,
  // Commit stage
  input  logic                          cmt_status_ena,
  input  logic                          cmt_mret_ena,
  input  logic                          cmt_epc_ena,
  input  csr_pkg::csr_word_t            cmt_epc,
  input  logic                          cmt_cause_ena,
  input  csr_pkg::csr_word_t            cmt_cause,
  input  logic                          cmt_instret_ena,
  input  logic                          ext_irq,
  input  logic                          sft_irq,
  input  logic                          tmr_irq,
  input  logic [csr_pkg::HART_ID_W-1:0] core_mhartid,
  output logic                          status_mie,
  output logic                          meie,
  output logic                          mtie,
  output logic                          msie,
  output logic                          tm_stop,
  output csr_pkg::csr_word_t            csr_epc,
  output csr_pkg::csr_word_t            csr_mtvec
);
  import csr_pkg::*;

  csr_sel_e   rd_sel;
  logic       wr_mstatus, wr_mie, wr_mtvec, wr_mscratch, wr_mepc, wr_mcause;
  logic       wr_counterstop, wr_mcycle, wr_mcycleh, wr_minstret, wr_minstreth;
  logic       status_mpie;
  logic [2:0] mie_bits;
  logic [2:0] mip_bits;
  logic [2:0] counterstop_r;                  // {ir, tm, cy} stop
  csr_word_t  mscratch_r, mcause_r;
  csr_word_t  mcycle_lo, mcycle_hi, minstret_lo, minstret_hi;

  csr_decode u_decode (
    .clk, .rst, .csr_ena, .csr_rd_en, .csr_wr_en, .csr_idx, .rd_sel, .csr_access_ilgl,
    .wr_mstatus, .wr_mie, .wr_mtvec, .wr_mscratch, .wr_mepc, .wr_mcause,
    .wr_counterstop, .wr_mcycle, .wr_mcycleh, .wr_minstret, .wr_minstreth
  );

  csr_machine_regs #(.MTVEC_RESET(MTVEC_RESET)) u_regs (
    .clk, .rst, .wr_mstatus, .wr_mie, .wr_mtvec, .wr_mscratch, .wr_mepc,
    .wr_mcause, .wr_counterstop, .wbck_csr_dat,
    .cmt_status_ena, .cmt_mret_ena, .cmt_epc_ena, .cmt_epc, .cmt_cause_ena, .cmt_cause,
    .ext_irq, .sft_irq, .tmr_irq, .status_mie, .status_mpie, .mie_bits, .mip_bits,
    .mtvec_r(csr_mtvec), .mscratch_r, .mepc_r(csr_epc), .mcause_r, .counterstop_r
  );

  // Cycles run unless stopped, instret counts retired instructions
  csr_counter u_cycle (
    .clk, .rst, .inc(~counterstop_r[0]), .wr_lo(wr_mcycle), .wr_hi(wr_mcycleh),
    .wbck_csr_dat, .cnt_lo(mcycle_lo), .cnt_hi(mcycle_hi)
  );

  csr_counter u_instret (
    .clk, .rst, .inc(cmt_instret_ena & ~counterstop_r[2]), .wr_lo(wr_minstret),
    .wr_hi(wr_minstreth), .wbck_csr_dat, .cnt_lo(minstret_lo), .cnt_hi(minstret_hi)
  );

  csr_read_mux u_read_mux (
    .rd_sel, .status_mie, .status_mpie, .mie_bits, .mip_bits,
    .mtvec_r(csr_mtvec), .mscratch_r, .mepc_r(csr_epc), .mcause_r, .counterstop_r,
    .mcycle_lo, .mcycle_hi, .minstret_lo, .minstret_hi, .core_mhartid, .read_csr_dat
  );

  assign meie    = mie_bits[2];
  assign mtie    = mie_bits[1];
  assign msie    = mie_bits[0];
  assign tm_stop = counterstop_r[1];          // Timer stop, used outside

endmodule

`default_nettype wire

// File: tb_csr_tasks.svh
//////////////////////////////////////////////////////////////////////
// Testbench helpers: error counters, compare tasks for CSR words
// and single-bit flags, LFSR word source and the reset wait
//////////////////////////////////////////////////////////////////////
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

localparam int RESET_TIMEOUT = 40;            // Cycles allowed for reset release

int          word_errs  = 0;
int          flag_errs  = 0;
int          timeouts   = 0;
logic [31:0] lfsr_state = 32'h4855bc88;      // Fixed seed

task automatic check_word(input string name, input csr_pkg::csr_word_t got,
                          input csr_pkg::csr_word_t exp);
  if (got !== exp) begin
    word_errs++;
    $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    flag_errs++;
    $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

// Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit taken
function automatic logic [31:0] random_word();
  logic [31:0] w;
  logic        fb;
  w = '0;
  for (int i = 0; i < 32; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    w          = {w[30:0], lfsr_state[31]};
    lfsr_state = {lfsr_state[30:0], fb};
  end
  return w;
endfunction

// Poll reset on rising edges, where it is stable
task automatic wait_reset_release(output logic ok);
  int cycles;
  ok     = 1'b0;
  cycles = 0;
  while (!ok && cycles < RESET_TIMEOUT) begin
    @(posedge clk);
    ok = ~rst;
    cycles++;
  end
  if (!ok) begin
    timeouts++;
    $display("Reset was still active after %0d cycles", RESET_TIMEOUT);
  end
endtask

`endif

// File: tb_csr_file.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the CSR file: clock and reset, a table of access
// and commit steps with expected values, and the loop applying it
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_csr_file;
  import csr_pkg::*;

  localparam int        CLK_PERIOD  = 100;
  localparam csr_word_t MTVEC_INIT  = 32'h0000_0200;
  localparam csr_word_t MIE_MASK    = 32'h0000_0888;  // Bits 11, 7 and 3
  localparam csr_word_t MEPC_MASK   = 32'hFFFF_FFFE;
  localparam csr_word_t MCAUSE_MASK = 32'h8000_000F;  // Interrupt flag and code
  localparam csr_word_t MPP_M       = 32'h0000_1800;

  typedef enum logic [2:0] {
    OP_IDLE, OP_READ, OP_WRITE, OP_TRAP, OP_MRET, OP_IRQ, OP_INSTRET, OP_PINS
  } op_e;

  typedef struct packed {
    op_e       op;
    csr_idx_t  idx;
    csr_word_t data;                            // Write data, epc or irq lines
    csr_word_t aux;                             // Trap cause
    csr_word_t exp;                             // Read value or output bits
    logic      ilgl;
  } step_t;

  logic                 clk, rst;
  logic                 csr_ena, csr_rd_en, csr_wr_en;
  csr_idx_t             csr_idx;
  csr_word_t            wbck_csr_dat, read_csr_dat;
  logic                 csr_access_ilgl;
  logic                 cmt_status_ena, cmt_mret_ena, cmt_epc_ena, cmt_cause_ena;
  csr_word_t            cmt_epc, cmt_cause;
  logic                 cmt_instret_ena;
  logic                 ext_irq, sft_irq, tmr_irq;
  logic [HART_ID_W-1:0] core_mhartid;
  logic                 status_mie, meie, mtie, msie, tm_stop;
  csr_word_t            csr_epc, csr_mtvec;
  step_t                steps[$];

  `include "tb_csr_tasks.svh"

  csr_file #(.MTVEC_RESET(MTVEC_INIT)) uut (.*);

  always #(CLK_PERIOD/2) clk = ~clk;

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    csr_ena         = 1'b0;
    csr_rd_en       = 1'b0;
    csr_wr_en       = 1'b0;
    csr_idx         = '0;
    wbck_csr_dat    = '0;
    cmt_status_ena  = 1'b0;
    cmt_mret_ena    = 1'b0;
    cmt_epc_ena     = 1'b0;
    cmt_epc         = '0;
    cmt_cause_ena   = 1'b0;
    cmt_cause       = '0;
    cmt_instret_ena = 1'b0;
    ext_irq         = 1'b0;
    sft_irq         = 1'b0;
    tmr_irq         = 1'b0;
    core_mhartid    = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////////////////////////
  task automatic add_step(input op_e op, input csr_idx_t idx, input csr_word_t data,
                          input csr_word_t aux, input csr_word_t exp, input logic ilgl);
    steps.push_back('{op, idx, data, aux, exp, ilgl});
  endtask

  task automatic add_write(input csr_idx_t idx, input csr_word_t data, input logic ilgl);
    add_step(OP_WRITE, idx, data, '0, '0, ilgl);
  endtask

  task automatic add_read(input csr_idx_t idx, input csr_word_t exp, input logic ilgl);
    add_step(OP_READ, idx, '0, '0, exp, ilgl);
  endtask

  // Expected {status_mie, meie, mtie, msie, tm_stop}
  task automatic add_pins(input logic st_mie, input logic [2:0] ie, input logic tms);
    add_step(OP_PINS, 12'h000, '0, '0, {27'd0, st_mie, ie, tms}, 1'b0);
  endtask

  task automatic build_table();
    csr_word_t  r;
    logic [2:0] ie;                             // {meie, mtie, msie} after mie write
    add_read(CSR_MTVEC, MTVEC_INIT, 1'b0);      // Reset values
    add_read(CSR_MSTATUS, MPP_M, 1'b0);
    r = random_word();
    add_write(CSR_MSCRATCH, r, 1'b0);
    add_read(CSR_MSCRATCH, r, 1'b0);
    r = random_word();
    add_write(CSR_MTVEC, r, 1'b0);
    add_read(CSR_MTVEC, r, 1'b0);
    r = random_word() | 32'h0000_0008;         // Keep at least one enable set
    ie = {r[11], r[7], r[3]};
    add_write(CSR_MIE, r, 1'b0);
    add_read(CSR_MIE, r & MIE_MASK, 1'b0);
    add_pins(1'b0, ie, 1'b0);
    r = random_word();
    add_write(CSR_MEPC, r, 1'b0);
    add_read(CSR_MEPC, r & MEPC_MASK, 1'b0);
    r = random_word();
    add_write(CSR_MCAUSE, r, 1'b0);
    add_read(CSR_MCAUSE, r & MCAUSE_MASK, 1'b0);
    // Identification and illegal accesses
    add_read(CSR_MISA, MISA_VALUE, 1'b0);
    add_read(CSR_MVENDORID, MVENDORID_VALUE, 1'b0);
    add_read(CSR_MARCHID, MARCHID_VALUE, 1'b0);
    add_read(CSR_MIMPID, MIMPID_VALUE, 1'b0);
    add_read(CSR_MHARTID, 32'h0000_0001, 1'b0);
    add_write(CSR_MVENDORID, random_word(), 1'b1);
    add_read(CSR_MVENDORID, MVENDORID_VALUE, 1'b0);
    add_read(12'h7C0, 32'h0, 1'b1);
    add_write(12'h7C0, random_word(), 1'b1);
    // Trap entry, then mret
    add_write(CSR_MSTATUS, 32'h0000_0008, 1'b0);
    add_read(CSR_MSTATUS, MPP_M | 32'h0000_0008, 1'b0);
    add_pins(1'b1, ie, 1'b0);
    r = random_word();
    add_step(OP_TRAP, 12'h000, r, 32'h8000_0007, '0, 1'b0);
    add_read(CSR_MEPC, r & MEPC_MASK, 1'b0);
    add_read(CSR_MCAUSE, 32'h8000_0007, 1'b0);
    add_read(CSR_MSTATUS, MPP_M | 32'h0000_0080, 1'b0);
    add_pins(1'b0, ie, 1'b0);
    add_step(OP_MRET, 12'h000, '0, '0, '0, 1'b0);
    add_read(CSR_MSTATUS, MPP_M | 32'h0000_0088, 1'b0);
    add_pins(1'b1, ie, 1'b0);
    // Interrupt lines {ext, tmr, sft} into mip
    add_step(OP_IRQ, 12'h000, 32'h1, '0, '0, 1'b0);
    add_read(CSR_MIP, 32'h0000_0008, 1'b0);
    add_step(OP_IRQ, 12'h000, 32'h2, '0, '0, 1'b0);
    add_read(CSR_MIP, 32'h0000_0080, 1'b0);
    add_step(OP_IRQ, 12'h000, 32'h4, '0, '0, 1'b0);
    add_read(CSR_MIP, 32'h0000_0800, 1'b0);
    add_step(OP_IRQ, 12'h000, 32'h0, '0, '0, 1'b0);
    add_read(CSR_MIP, 32'h0, 1'b0);
    // Counters, all stopped first
    add_write(CSR_COUNTERSTOP, 32'h7, 1'b0);
    add_read(CSR_COUNTERSTOP, 32'h7, 1'b0);
    add_pins(1'b1, ie, 1'b1);
    r = random_word();
    add_write(CSR_MCYCLE, r, 1'b0);
    repeat (3) add_step(OP_IDLE, 12'h000, '0, '0, '0, 1'b0);
    add_read(CSR_MCYCLE, r, 1'b0);
    add_write(CSR_MINSTRET, 32'hFFFF_FFFF, 1'b0);
    add_write(CSR_MINSTRETH, 32'h5, 1'b0);
    add_step(OP_INSTRET, 12'h000, '0, '0, '0, 1'b0);  // Stopped, no count
    add_read(CSR_MINSTRET, 32'hFFFF_FFFF, 1'b0);
    add_write(CSR_COUNTERSTOP, 32'h0, 1'b0);
    add_step(OP_INSTRET, 12'h000, '0, '0, '0, 1'b0);
    add_read(CSR_MINSTRET, 32'h0, 1'b0);
    add_read(CSR_MINSTRETH, 32'h6, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Step driver and checker
  //////////////////////////////////////////////////////////////////////
  task automatic drive_idle();                // Irq lines keep their level
    csr_ena         = 1'b0;
    csr_rd_en       = 1'b0;
    csr_wr_en       = 1'b0;
    csr_idx         = '0;
    wbck_csr_dat    = '0;
    cmt_status_ena  = 1'b0;
    cmt_mret_ena    = 1'b0;
    cmt_epc_ena     = 1'b0;
    cmt_cause_ena   = 1'b0;
    cmt_instret_ena = 1'b0;
  endtask

  task automatic apply_step(input step_t s);
    case (s.op)
      OP_READ: begin
        csr_ena   = 1'b1;
        csr_rd_en = 1'b1;
        csr_idx   = s.idx;
      end
      OP_WRITE: begin
        csr_ena      = 1'b1;
        csr_wr_en    = 1'b1;
        csr_idx      = s.idx;
        wbck_csr_dat = s.data;
      end
      OP_TRAP: begin
        cmt_status_ena = 1'b1;
        cmt_epc_ena    = 1'b1;
        cmt_epc        = s.data;
        cmt_cause_ena  = 1'b1;
        cmt_cause      = s.aux;
      end
      OP_MRET:    cmt_mret_ena = 1'b1;
      OP_IRQ:     {ext_irq, tmr_irq, sft_irq} = s.data[2:0];
      OP_INSTRET: cmt_instret_ena = 1'b1;
      default:    ;                           // Idle and output checks drive nothing
    endcase
  endtask

  task automatic check_step(input step_t s, input int n);
    case (s.op)
      OP_READ: begin
        check_word($sformatf("step %0d read_csr_dat", n), read_csr_dat, s.exp);
        check_bit($sformatf("step %0d csr_access_ilgl", n), csr_access_ilgl, s.ilgl);
        if (s.idx == CSR_MEPC)                // Exported mepc matches its read image
          check_word($sformatf("step %0d csr_epc", n), csr_epc, s.exp);
        if (s.idx == CSR_MTVEC)
          check_word($sformatf("step %0d csr_mtvec", n), csr_mtvec, s.exp);
      end
      OP_WRITE: check_bit($sformatf("step %0d csr_access_ilgl", n), csr_access_ilgl, s.ilgl);
      OP_PINS: begin
        check_bit($sformatf("step %0d status_mie", n), status_mie, s.exp[4]);
        check_bit($sformatf("step %0d meie", n), meie, s.exp[3]);
        check_bit($sformatf("step %0d mtie", n), mtie, s.exp[2]);
        check_bit($sformatf("step %0d msie", n), msie, s.exp[1]);
        check_bit($sformatf("step %0d tm_stop", n), tm_stop, s.exp[0]);
      end
      default: ;
    endcase
  endtask

  initial begin : main
    step_t s;
    logic  rst_ok;
    build_table();
    wait_reset_release(rst_ok);
    if (rst_ok) begin
      for (int n = 0; n < steps.size(); n++) begin
        s = steps[n];
        @(negedge clk);
        drive_idle();
        apply_step(s);
        #(CLK_PERIOD/4);                      // Mid low phase, outputs settled
        check_step(s, n);
      end
      @(negedge clk);
      drive_idle();
    end
    $display("Errors: %0d word, %0d flag, %0d timeout", word_errs, flag_errs, timeouts);
    if (word_errs + flag_errs + timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_machine_regs.sv
csr_counter.sv
csr_read_mux.sv
csr_file.sv
tb_csr_file.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSR file testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_csr_file \
  -Mdir obj_dir -o sim_csr_file
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_csr_file > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
